// ==== design/rs_pkg.sv ====
package rs_pkg;

    parameter int TAG_W = 6;
    parameter int OP_W  = 4;

    // Default configuration of the station
    parameter int DEF_DEPTH          = 8;
    parameter int DEF_DISPATCH_WIDTH = 2;
    parameter int DEF_CDB_WIDTH      = 2;
    parameter int DEF_NUM_ALU        = 2;
    parameter int DEF_NUM_MULT       = 1;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [OP_W-1:0]  op_t;

    typedef enum logic {
        FU_ALU,
        FU_MULT
    } fu_class_e;

    typedef struct packed {
        tag_t tag;
        logic ready;
    } src_t;

    typedef struct packed {
        logic      valid;
        fu_class_e fu_class;
        op_t       op;
        tag_t      dest;
        src_t      src1;
        src_t      src2;
    } dispatch_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } cdb_t;

    // Packet handed to a functional unit
    typedef struct packed {
        logic valid;
        op_t  op;
        tag_t dest;
        tag_t src1;
        tag_t src2;
    } issue_t;

endpackage

// ==== design/slot_alloc.sv ====
`timescale 1ns/1ps

module slot_alloc #(
    parameter int DEPTH          = 8,
    parameter int DISPATCH_WIDTH = 2
) (
    input  logic [DEPTH-1:0]                        free_slots,
    output logic [DISPATCH_WIDTH-1:0][DEPTH-1:0]    slot_grant,
    output logic [$clog2(DISPATCH_WIDTH+1)-1:0]     open_entries
);
    localparam int CNT_W  = $clog2(DEPTH+1);
    localparam int OPEN_W = $clog2(DISPATCH_WIDTH+1);

    logic [CNT_W-1:0] free_count;

    // Lane 0 takes the lowest free slot, each later lane the next one up
    always_comb begin
        logic [DEPTH-1:0] left;
        logic             found;
        left       = free_slots;
        slot_grant = '0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            found = 1'b0;
            for (int j = 0; j < DEPTH; j++) begin
                if (left[j] && !found) begin
                    slot_grant[i][j] = 1'b1;
                    left[j]          = 1'b0;
                    found            = 1'b1;
                end
            end
        end
    end

    // Population count of free slots
    always_comb begin
        free_count = '0;
        for (int j = 0; j < DEPTH; j++) begin
            free_count = free_count + CNT_W'(free_slots[j]);
        end
    end

    // A lane with no free slot left gets an all-zero grant, so the cap
    // below is exactly the number of lanes holding a grant
    always_comb begin
        if (int'(free_count) > DISPATCH_WIDTH) begin
            open_entries = OPEN_W'(DISPATCH_WIDTH);
        end else begin
            open_entries = OPEN_W'(free_count);
        end
    end

endmodule

// ==== design/rs_entry_array.sv ====
`timescale 1ns/1ps

module rs_entry_array #(
    parameter int DEPTH          = 8,
    parameter int DISPATCH_WIDTH = 2,
    parameter int CDB_WIDTH      = 2
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  rs_pkg::dispatch_t [DISPATCH_WIDTH-1:0]  dispatch,
    input  logic [DISPATCH_WIDTH-1:0][DEPTH-1:0]    slot_grant,
    input  rs_pkg::cdb_t      [CDB_WIDTH-1:0]       cdb,
    input  logic              [DEPTH-1:0]           alu_issued,
    input  logic              [DEPTH-1:0]           mult_issued,
    output logic              [DEPTH-1:0]           free_slots,
    output logic              [DEPTH-1:0]           alu_req,
    output logic              [DEPTH-1:0]           mult_req,
    output rs_pkg::issue_t    [DEPTH-1:0]           entry_pkts
);
    import rs_pkg::*;

    typedef struct packed {
        fu_class_e fu_class;
        op_t       op;
        tag_t      dest;
        src_t      src1;
        src_t      src2;
    } entry_t;

    logic   [DEPTH-1:0] valid_q;
    logic   [DEPTH-1:0] valid_d;
    logic   [DEPTH-1:0] write_mask;
    entry_t [DEPTH-1:0] entry_q;
    entry_t [DEPTH-1:0] entry_d;

    // Marks a source ready when any CDB lane broadcasts its tag
    function automatic src_t wake(src_t src, cdb_t [CDB_WIDTH-1:0] bus);
        src_t result;
        result = src;
        for (int c = 0; c < CDB_WIDTH; c++) begin
            if (bus[c].valid && bus[c].tag == src.tag) begin
                result.ready = 1'b1;
            end
        end
        return result;
    endfunction

    always_comb begin
        write_mask = '0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (dispatch[i].valid) begin
                write_mask = write_mask | slot_grant[i];
            end
        end
    end

    // Wakeup first, then dispatch writes win so new lanes keep their own ready bits
    always_comb begin
        entry_d = entry_q;
        for (int j = 0; j < DEPTH; j++) begin
            entry_d[j].src1 = wake(entry_q[j].src1, cdb);
            entry_d[j].src2 = wake(entry_q[j].src2, cdb);
        end
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            for (int j = 0; j < DEPTH; j++) begin
                if (dispatch[i].valid && slot_grant[i][j]) begin
                    entry_d[j].fu_class = dispatch[i].fu_class;
                    entry_d[j].op       = dispatch[i].op;
                    entry_d[j].dest     = dispatch[i].dest;
                    entry_d[j].src1     = dispatch[i].src1;
                    entry_d[j].src2     = dispatch[i].src2;
                end
            end
        end
    end

    assign valid_d = (valid_q & ~(alu_issued | mult_issued)) | write_mask;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clock) begin
        entry_q <= entry_d;
    end

    assign free_slots = ~valid_q;

    always_comb begin
        logic both_ready;
        for (int j = 0; j < DEPTH; j++) begin
            both_ready = entry_q[j].src1.ready && entry_q[j].src2.ready;
            alu_req[j]  = valid_q[j] && both_ready && entry_q[j].fu_class == FU_ALU;
            mult_req[j] = valid_q[j] && both_ready && entry_q[j].fu_class == FU_MULT;
            entry_pkts[j].valid = valid_q[j];
            entry_pkts[j].op    = entry_q[j].op;
            entry_pkts[j].dest  = entry_q[j].dest;
            entry_pkts[j].src1  = entry_q[j].src1.tag;
            entry_pkts[j].src2  = entry_q[j].src2.tag;
        end
    end

    // Allocator grants only slots this array reports as free
    assert property (@(posedge clock) disable iff (reset)
        (write_mask & valid_q) == '0)
        else $error("dispatch wrote an occupied slot");

    // Selectors only grant slots that hold an instruction
    assert property (@(posedge clock) disable iff (reset)
        ((alu_issued | mult_issued) & ~valid_q) == '0)
        else $error("issue from an empty slot");

endmodule

// ==== design/issue_select.sv ====
`timescale 1ns/1ps

module issue_select #(
    parameter int DEPTH  = 8,
    parameter int NUM_FU = 2
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic           [DEPTH-1:0]        req,
    input  logic           [NUM_FU-1:0]       busy,
    input  rs_pkg::issue_t [DEPTH-1:0]        entry_pkts,
    output logic           [DEPTH-1:0]        issued,
    output rs_pkg::issue_t [NUM_FU-1:0]       issue
);
    import rs_pkg::*;

    logic   [NUM_FU-1:0] grant_valid;
    issue_t [NUM_FU-1:0] grant_pkt;
    logic   [NUM_FU-1:0] valid_q;
    issue_t [NUM_FU-1:0] pkt_q;

    // Idle units in ascending order each take the lowest remaining request
    always_comb begin
        logic [DEPTH-1:0] left;
        left        = req;
        issued      = '0;
        grant_valid = '0;
        grant_pkt   = '0;
        for (int u = 0; u < NUM_FU; u++) begin
            if (!busy[u]) begin
                for (int j = 0; j < DEPTH; j++) begin
                    if (left[j] && !grant_valid[u]) begin
                        grant_valid[u] = 1'b1;
                        grant_pkt[u]   = entry_pkts[j];
                        issued[j]      = 1'b1;
                        left[j]        = 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= grant_valid;
        end
    end

    always_ff @(posedge clock) begin
        pkt_q <= grant_pkt;
    end

    // Issue valid comes from the control register only
    always_comb begin
        for (int u = 0; u < NUM_FU; u++) begin
            issue[u]       = pkt_q[u];
            issue[u].valid = valid_q[u];
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        (issued & ~req) == '0)
        else $error("grant without a ready request");

    // A packet only lands on a unit that was idle when it was chosen
    assert property (@(posedge clock) disable iff (reset)
        (valid_q & $past(busy)) == '0)
        else $error("issue to a busy unit");

endmodule

// ==== design/rs_top.sv ====
`timescale 1ns/1ps

module rs_top #(
    parameter int DEPTH          = rs_pkg::DEF_DEPTH,
    parameter int DISPATCH_WIDTH = rs_pkg::DEF_DISPATCH_WIDTH,
    parameter int CDB_WIDTH      = rs_pkg::DEF_CDB_WIDTH,
    parameter int NUM_ALU        = rs_pkg::DEF_NUM_ALU,
    parameter int NUM_MULT       = rs_pkg::DEF_NUM_MULT
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  rs_pkg::dispatch_t [DISPATCH_WIDTH-1:0]      dispatch,
    input  rs_pkg::cdb_t      [CDB_WIDTH-1:0]           cdb,
    input  logic              [NUM_ALU-1:0]             alu_busy,
    input  logic              [NUM_MULT-1:0]            mult_busy,
    output logic              [$clog2(DISPATCH_WIDTH+1)-1:0] open_entries,
    output rs_pkg::issue_t    [NUM_ALU-1:0]             issue_alu,
    output rs_pkg::issue_t    [NUM_MULT-1:0]            issue_mult
);
    import rs_pkg::*;

    logic   [DEPTH-1:0]                      free_slots;
    logic   [DISPATCH_WIDTH-1:0][DEPTH-1:0]  slot_grant;
    logic   [DEPTH-1:0]                      alu_req;
    logic   [DEPTH-1:0]                      mult_req;
    logic   [DEPTH-1:0]                      alu_issued;
    logic   [DEPTH-1:0]                      mult_issued;
    issue_t [DEPTH-1:0]                      entry_pkts;

    slot_alloc #(
        .DEPTH          (DEPTH),
        .DISPATCH_WIDTH (DISPATCH_WIDTH)
    ) alloc (
        .free_slots   (free_slots),
        .slot_grant   (slot_grant),
        .open_entries (open_entries)
    );

    rs_entry_array #(
        .DEPTH          (DEPTH),
        .DISPATCH_WIDTH (DISPATCH_WIDTH),
        .CDB_WIDTH      (CDB_WIDTH)
    ) entries (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dispatch),
        .slot_grant  (slot_grant),
        .cdb         (cdb),
        .alu_issued  (alu_issued),
        .mult_issued (mult_issued),
        .free_slots  (free_slots),
        .alu_req     (alu_req),
        .mult_req    (mult_req),
        .entry_pkts  (entry_pkts)
    );

    issue_select #(
        .DEPTH  (DEPTH),
        .NUM_FU (NUM_ALU)
    ) alu_select (
        .clock      (clock),
        .reset      (reset),
        .req        (alu_req),
        .busy       (alu_busy),
        .entry_pkts (entry_pkts),
        .issued     (alu_issued),
        .issue      (issue_alu)
    );

    issue_select #(
        .DEPTH  (DEPTH),
        .NUM_FU (NUM_MULT)
    ) mult_select (
        .clock      (clock),
        .reset      (reset),
        .req        (mult_req),
        .busy       (mult_busy),
        .entry_pkts (entry_pkts),
        .issued     (mult_issued),
        .issue      (issue_mult)
    );

endmodule

// ==== sim/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// ==== sim/rs_tb.sv ====
`timescale 1ns/1ps

module rs_tb;
    import rs_pkg::*;

    localparam int DEPTH           = DEF_DEPTH;
    localparam int DW              = DEF_DISPATCH_WIDTH;
    localparam int CW              = DEF_CDB_WIDTH;
    localparam int NA              = DEF_NUM_ALU;
    localparam int NM              = DEF_NUM_MULT;
    localparam int OPEN_W          = $clog2(DW + 1);
    localparam int DIRECTED_CYCLES = 33;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int CYCLE_LIMIT     = 2 * (DIRECTED_CYCLES + RANDOM_CYCLES) + 100;

    logic                   clock;
    logic                   reset;
    dispatch_t [DW-1:0]     dispatch;
    cdb_t      [CW-1:0]     cdb;
    logic      [NA-1:0]     alu_busy;
    logic      [NM-1:0]     mult_busy;
    logic      [OPEN_W-1:0] open_entries;
    issue_t    [NA-1:0]     issue_alu;
    issue_t    [NM-1:0]     issue_mult;

    // Reference model of the slot array and the registered issue outputs
    logic      [DEPTH-1:0]  m_valid;
    dispatch_t              m_entry [DEPTH];
    issue_t    [NA-1:0]     exp_alu;
    issue_t    [NM-1:0]     exp_mult;
    int                     cycle_count = 0;

    clock_gen clocks (
        .clock (clock),
        .reset (reset)
    );

    rs_top #(
        .DEPTH          (DEPTH),
        .DISPATCH_WIDTH (DW),
        .CDB_WIDTH      (CW),
        .NUM_ALU        (NA),
        .NUM_MULT       (NM)
    ) DUT (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .cdb          (cdb),
        .alu_busy     (alu_busy),
        .mult_busy    (mult_busy),
        .open_entries (open_entries),
        .issue_alu    (issue_alu),
        .issue_mult   (issue_mult)
    );

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            stop_with_failure();
        end
    end

    task automatic check_count(input string name, input logic [OPEN_W-1:0] got,
                               input logic [OPEN_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // Fields of an idle unit carry no meaning, only valid is compared then
    task automatic check_issue(input string name, input issue_t got, input issue_t exp);
        logic bad;
        bad = exp.valid ? (got !== exp) : (got.valid !== 1'b0);
        if (bad) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic logic [OPEN_W-1:0] expected_open();
        int nfree;
        nfree = 0;
        for (int j = 0; j < DEPTH; j++) begin
            nfree = nfree + (m_valid[j] ? 0 : 1);
        end
        return (nfree < DW) ? OPEN_W'(nfree) : OPEN_W'(DW);
    endfunction

    // Lowest ready slot of the class that no earlier unit took this cycle
    task automatic pair_unit(input fu_class_e cls, input logic busy,
                             inout logic [DEPTH-1:0] taken, output issue_t pkt);
        pkt = '0;
        for (int j = 0; j < DEPTH; j++) begin
            if (!busy && !pkt.valid && m_valid[j] && !taken[j] && m_entry[j].fu_class == cls
                    && m_entry[j].src1.ready && m_entry[j].src2.ready) begin
                pkt.valid = 1'b1;
                pkt.op    = m_entry[j].op;
                pkt.dest  = m_entry[j].dest;
                pkt.src1  = m_entry[j].src1.tag;
                pkt.src2  = m_entry[j].src2.tag;
                taken[j]  = 1'b1;
            end
        end
    endtask

    task automatic model_step();
        logic [DEPTH-1:0]  free_pre;
        logic [DEPTH-1:0]  taken;
        logic [OPEN_W-1:0] open;
        issue_t            pkt;
        int                lane;
        free_pre = ~m_valid;
        open     = expected_open();
        taken    = '0;
        for (int u = 0; u < NA; u++) begin
            pair_unit(FU_ALU, alu_busy[u], taken, pkt);
            exp_alu[u] = pkt;
        end
        for (int u = 0; u < NM; u++) begin
            pair_unit(FU_MULT, mult_busy[u], taken, pkt);
            exp_mult[u] = pkt;
        end
        m_valid = m_valid & ~taken;
        for (int j = 0; j < DEPTH; j++) begin
            for (int c = 0; c < CW; c++) begin
                if (cdb[c].valid && cdb[c].tag == m_entry[j].src1.tag)
                    m_entry[j].src1.ready = 1'b1;
                if (cdb[c].valid && cdb[c].tag == m_entry[j].src2.tag)
                    m_entry[j].src2.ready = 1'b1;
            end
        end
        // Free slots in ascending order belong to lanes 0, 1 and so on
        lane = 0;
        for (int j = 0; j < DEPTH; j++) begin
            if (free_pre[j]) begin
                if (lane < int'(open) && dispatch[lane].valid) begin
                    m_entry[j] = dispatch[lane];
                    m_valid[j] = 1'b1;
                end
                lane++;
            end
        end
    endtask

    task automatic compare_outputs();
        check_count("open_entries", open_entries, expected_open());
        for (int u = 0; u < NA; u++) begin
            check_issue($sformatf("issue_alu[%0d]", u), issue_alu[u], exp_alu[u]);
        end
        for (int u = 0; u < NM; u++) begin
            check_issue($sformatf("issue_mult[%0d]", u), issue_mult[u], exp_mult[u]);
        end
    endtask

    task automatic step(input dispatch_t [DW-1:0] d, input cdb_t [CW-1:0] c,
                        input logic [NA-1:0] ab, input logic [NM-1:0] mb);
        @(posedge clock);
        model_step();
        dispatch  <= d;
        cdb       <= c;
        alu_busy  <= ab;
        mult_busy <= mb;
        @(negedge clock);
        compare_outputs();
    endtask

    function automatic dispatch_t make_lane(fu_class_e cls, tag_t wait_tag, logic ready);
        dispatch_t lane;
        lane.valid      = 1'b1;
        lane.fu_class   = cls;
        lane.op         = op_t'(wait_tag);
        lane.dest       = ~wait_tag;
        lane.src1.tag   = wait_tag;
        lane.src1.ready = ready;
        lane.src2.tag   = tag_t'(1);
        lane.src2.ready = 1'b1;
        return lane;
    endfunction

    function automatic cdb_t broadcast(tag_t tag);
        cdb_t lane;
        lane.valid = 1'b1;
        lane.tag   = tag;
        return lane;
    endfunction

    // Source tags stay in 0..15 so that CDB traffic hits often
    function automatic dispatch_t random_lane();
        dispatch_t lane;
        lane.valid      = ($urandom_range(3) != 0);
        lane.fu_class   = ($urandom_range(2) == 0) ? FU_MULT : FU_ALU;
        lane.op         = op_t'($urandom);
        lane.dest       = tag_t'($urandom);
        lane.src1.tag   = tag_t'($urandom_range(15));
        lane.src1.ready = ($urandom_range(1) != 0);
        lane.src2.tag   = tag_t'($urandom_range(15));
        lane.src2.ready = ($urandom_range(2) != 0);
        return lane;
    endfunction

    initial begin
        dispatch_t [DW-1:0] d;
        cdb_t      [CW-1:0] c;
        void'($urandom(32'hd26a3608));
        dispatch  = '0;
        cdb       = '0;
        alu_busy  = '0;
        mult_busy = '0;
        m_valid   = '0;
        exp_alu   = '0;
        exp_mult  = '0;
        wait (reset == 1'b0);
        @(negedge clock);
        compare_outputs();

        // Fill with waiting instructions, the last two cycles of lanes find no room
        for (int k = 0; k < 6; k++) begin
            d[0] = make_lane(FU_ALU, tag_t'(32 + 2 * k), 1'b0);
            d[1] = make_lane((k % 2 == 1) ? FU_MULT : FU_ALU, tag_t'(33 + 2 * k), 1'b0);
            step(d, '0, '0, '0);
        end
        step('0, '0, '0, '0);
        check_count("open_entries", open_entries, '0);

        c[0] = broadcast(tag_t'(32));
        c[1] = broadcast(tag_t'(33));
        step('0, c, '0, '0);
        c[0] = broadcast(tag_t'(34));
        c[1] = broadcast(tag_t'(35));
        step('0, c, '0, '0);
        step('0, '0, '0, '0);

        // Tag 50 on the CDB in the same cycle as its waiter arrives
        d    = '0;
        d[0] = make_lane(FU_ALU, tag_t'(50), 1'b0);
        c    = '0;
        c[0] = broadcast(tag_t'(50));
        step(d, c, '0, '0);
        repeat (3) step('0, '0, '0, '0);

        // ALUs held busy, the multiplier entry still goes
        c[0] = broadcast(tag_t'(36));
        c[1] = broadcast(tag_t'(37));
        step('0, c, '1, '0);
        c[0] = broadcast(tag_t'(38));
        c[1] = broadcast(tag_t'(39));
        step('0, c, '1, '0);
        repeat (3) step('0, '0, '1, '0);
        step('0, '0, NA'(1), '0);
        repeat (2) step('0, '0, '1, '0);
        c    = '0;
        c[0] = broadcast(tag_t'(50));
        step('0, c, '0, '0);
        repeat (4) step('0, '0, '0, '0);

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            for (int i = 0; i < DW; i++) begin
                d[i] = random_lane();
            end
            for (int i = 0; i < CW; i++) begin
                c[i].valid = ($urandom_range(1) != 0);
                c[i].tag   = tag_t'($urandom_range(15));
            end
            step(d, c, NA'($urandom & $urandom), NM'($urandom & $urandom));
        end
        repeat (4) step('0, '0, '0, '0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
design/rs_pkg.sv
design/slot_alloc.sv
design/rs_entry_array.sv
design/issue_select.sv
design/rs_top.sv
sim/clock_gen.sv
sim/rs_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module rs_tb -f verilog.f

run: build
	./obj_dir/Vrs_tb | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module rs_tb -f verilog.f

clean:
	rm -rf obj_dir $(LOG)
